// ==== files.f ====
design/tl_mon_pkg.sv
design/tl_mon_if.sv
design/tl_a_checker.sv
design/tl_pend_table.sv
design/tl_d_checker.sv
design/tl_ul_monitor.sv
testbench/tb_tl_ul_monitor.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the TL-UL monitor testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_tl_ul_monitor -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== testbench/tb_tl_ul_monitor.sv ====
/*
 * Testbench for the TL-UL monitor with directed and random traffic,
 * a reference model of the A and D rules, a compare process and a report.
 */
`timescale 1ns/1ps

module tb_tl_ul_monitor import tl_mon_pkg::*; ();

  // Cycles a beat may wait for ready before it is given up.
  localparam int HS_TIMEOUT  = 50;
  localparam int RAND_CYCLES = 400;

  logic                clk_i;
  logic                rst_ni;
  logic                a_valid;
  logic                a_ready;
  logic [OPCODE_W-1:0] a_opcode;
  logic [PARAM_W-1:0]  a_param;
  logic [SIZE_W-1:0]   a_size;
  logic [SRC_W-1:0]    a_source;
  logic [ADDR_W-1:0]   a_address;
  logic [MASK_W-1:0]   a_mask;
  logic                a_corrupt;
  logic                d_valid;
  logic                d_ready;
  logic [OPCODE_W-1:0] d_opcode;
  logic [PARAM_W-1:0]  d_param;
  logic [SIZE_W-1:0]   d_size;
  logic [SRC_W-1:0]    d_source;
  logic                d_denied;
  logic                d_corrupt;
  a_err_t              a_err;
  d_err_t              d_err;
  logic [NUM_SRC-1:0]  pending;

  // Shadow of the pending table and the expected outputs.
  logic [NUM_SRC-1:0]  sh_valid;
  logic [NUM_SRC-1:0]  sh_get;
  logic [SIZE_W-1:0]   sh_size [NUM_SRC];
  a_err_t              exp_a;
  d_err_t              exp_d;
  logic [NUM_SRC-1:0]  exp_pend;
  logic                model_live;
  integer              seed;
  int                  n_checks;
  int                  n_errors;
  int                  n_tests;
  int                  errs_at_start;
  string               cur_test;

  tl_ul_monitor uut (.*);

  always #5 clk_i = ~clk_i;

  ////////////////////
  // Reference rules.
  ////////////////////

  function automatic a_err_t ref_a_err(input logic [2:0] op, input logic [2:0] param,
      input logic [1:0] size, input logic [31:0] addr, input logic [3:0] mask,
      input logic corrupt, input logic busy);
    a_err_t     e;
    int         nbytes;
    int         lane;
    int         ones;
    logic [3:0] allowed;
    logic [4:0] run;
    logic       legal;
    logic       contig;
    e      = '0;
    nbytes = 1 << int'(size);
    lane   = int'(addr[1:0]);
    ones   = 0;
    legal  = (op == OP_PUT_FULL) || (op == OP_PUT_PARTIAL) || (op == OP_GET);
    // A whole-beat transfer may use every lane.
    // A narrower one covers nbytes from the addressed lane.
    for (int i = 0; i < 4; i++) begin
      allowed[i] = (nbytes >= 4) || ((i >= lane) && (i < lane + nbytes));
      ones       = ones + int'(mask[i]);
    end
    // Drop trailing zeros, then a single run of ones is all-ones.
    run = {1'b0, mask};
    while (run != 5'd0 && run[0] == 1'b0) begin
      run = run >> 1;
    end
    contig            = ((run & (run + 5'd1)) == 5'd0);
    e[AE_OPCODE]      = !legal;
    e[AE_PARAM]       = (param != 3'd0);
    e[AE_SIZE]        = (nbytes > 4);
    e[AE_ALIGN]       = (int'(addr[2:0]) % nbytes) != 0;
    e[AE_MASK]        = ((mask & ~allowed) != 4'd0) ||
                        ((op == OP_GET || op == OP_PUT_FULL) && !contig);
    e[AE_FULL_MASK]   = (op == OP_PUT_FULL) && (ones != nbytes);
    e[AE_CORRUPT]     = corrupt && (op == OP_GET);
    e[AE_REUSE]       = legal && busy;
    return e;
  endfunction

  function automatic d_err_t ref_d_err(input logic [2:0] op, input logic [2:0] param,
      input logic [1:0] size, input logic denied, input logic corrupt,
      input logic req_valid, input logic req_get, input logic [1:0] req_size);
    d_err_t e;
    e             = '0;
    e[DE_OPCODE]  = (op != OP_ACCESS_ACK) && (op != OP_ACCESS_ACK_DATA);
    e[DE_NO_REQ]  = !req_valid;
    e[DE_MATCH]   = req_valid && ((op == OP_ACCESS_ACK_DATA && !req_get) ||
                                  (op == OP_ACCESS_ACK && req_get));
    e[DE_SIZE]    = req_valid && (size != req_size);
    e[DE_PARAM]   = (param != 3'd0);
    e[DE_CORRUPT] = (op == OP_ACCESS_ACK && corrupt) ||
                    (op == OP_ACCESS_ACK_DATA && denied && !corrupt);
    return e;
  endfunction

  // Model samples the same beats as the DUT and predicts the next outputs.
  always @(posedge clk_i) begin : model
    logic a_fire;
    logic d_fire;
    logic busy;
    a_fire     = a_valid && a_ready;
    d_fire     = d_valid && d_ready;
    model_live = rst_ni;
    if (!rst_ni) begin
      exp_a    = '0;
      exp_d    = '0;
      sh_valid = '0;
    end else begin
      exp_d = d_fire ? ref_d_err(d_opcode, d_param, d_size, d_denied, d_corrupt,
                                 sh_valid[d_source], sh_get[d_source],
                                 sh_size[d_source]) : '0;
      // A response on the same source frees it before the new request.
      busy  = sh_valid[a_source] && !(d_fire && d_source == a_source);
      exp_a = a_fire ? ref_a_err(a_opcode, a_param, a_size, a_address, a_mask,
                                 a_corrupt, busy) : '0;
      if (d_fire) begin
        sh_valid[d_source] = 1'b0;
      end
      if (a_fire && !busy && !exp_a[AE_OPCODE]) begin
        sh_valid[a_source] = 1'b1;
        sh_get[a_source]   = (a_opcode == OP_GET);
        sh_size[a_source]  = a_size;
      end
    end
    exp_pend = sh_valid;
  end

  ////////////////////
  // Checks.
  ////////////////////

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
      input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Outputs are registered, so the falling edge sees them settled.
  always @(negedge clk_i) begin
    if (model_live) begin
      check_val(32'(a_err), 32'(exp_a), "a_err vs model");
      check_val(32'(d_err), 32'(exp_d), "d_err vs model");
      check_val(32'(pending), 32'(exp_pend), "pending vs model");
    end
  end

  task automatic report_timeout(input string what);
    n_errors++;
    $display("Timeout: %s was not accepted within %0d cycles", what, HS_TIMEOUT);
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    errs_at_start = n_errors;
    n_tests++;
  endtask

  task automatic end_test();
    if (n_errors == errs_at_start) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d mismatches", cur_test, n_errors - errs_at_start);
    end
  endtask

  ////////////////////
  // Beat drivers.
  ////////////////////

  // Holds the A beat with random ready until it is taken.
  // Returns on the falling edge where a_err shows the result.
  task automatic send_a(input logic [2:0] op, input logic [2:0] param,
      input logic [1:0] size, input logic [1:0] src, input logic [31:0] addr,
      input logic [3:0] mask, input logic corrupt);
    int   waited;
    logic fired;
    waited    = 0;
    fired     = 1'b0;
    a_valid   = 1'b1;
    a_opcode  = op;
    a_param   = param;
    a_size    = size;
    a_source  = src;
    a_address = addr;
    a_mask    = mask;
    a_corrupt = corrupt;
    while (!fired && waited < HS_TIMEOUT) begin
      a_ready = ($random(seed) & 3) != 0;
      @(posedge clk_i);
      fired = a_ready;
      @(negedge clk_i);
      waited++;
    end
    if (!fired) begin
      report_timeout("A beat");
    end
    a_valid = 1'b0;
  endtask

  task automatic send_d(input logic [2:0] op, input logic [2:0] param,
      input logic [1:0] size, input logic [1:0] src, input logic denied,
      input logic corrupt);
    int   waited;
    logic fired;
    waited    = 0;
    fired     = 1'b0;
    d_valid   = 1'b1;
    d_opcode  = op;
    d_param   = param;
    d_size    = size;
    d_source  = src;
    d_denied  = denied;
    d_corrupt = corrupt;
    while (!fired && waited < HS_TIMEOUT) begin
      d_ready = ($random(seed) & 3) != 0;
      @(posedge clk_i);
      fired = d_ready;
      @(negedge clk_i);
      waited++;
    end
    if (!fired) begin
      report_timeout("D beat");
    end
    d_valid = 1'b0;
  endtask

  // One A request on source 3 expected to raise one bit, or none for bitpos < 0.
  task automatic req_expect(input logic [2:0] op, input logic [2:0] param,
      input logic [1:0] size, input logic [31:0] addr, input logic [3:0] mask,
      input logic corrupt, input int bitpos, input string what);
    send_a(op, param, size, 2'd3, addr, mask, corrupt);
    check_val(32'(a_err), (bitpos < 0) ? 32'd0 : (32'd1 << bitpos), what);
    // Legal opcodes were tracked and are closed again.
    if (op == OP_GET || op == OP_PUT_FULL || op == OP_PUT_PARTIAL) begin
      send_d((op == OP_GET) ? OP_ACCESS_ACK_DATA : OP_ACCESS_ACK, 3'd0, size, 2'd3,
             1'b0, 1'b0);
      check_val(32'(d_err), 32'd0, "closing response");
    end
  endtask

  // Legal 4-byte request on source 2, then one response expected to raise one bit.
  task automatic resp_expect(input logic is_get, input logic [2:0] op,
      input logic [2:0] param, input logic [1:0] size, input logic denied,
      input logic corrupt, input int bitpos, input string what);
    send_a(is_get ? OP_GET : OP_PUT_FULL, 3'd0, 2'd2, 2'd2, 32'h200, 4'hF, 1'b0);
    check_val(32'(a_err), 32'd0, "request before D fault");
    send_d(op, param, size, 2'd2, denied, corrupt);
    check_val(32'(d_err), 32'd1 << bitpos, what);
    check_val(32'(pending), 32'd0, "pending after D fault");
  endtask

  ////////////////////
  // Test sequence.
  ////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] r3;
    int          off;
    seed       = 32'h53358289;
    n_checks   = 0;
    n_errors   = 0;
    n_tests    = 0;
    model_live = 1'b0;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    a_valid    = 1'b0;
    a_ready    = 1'b0;
    a_opcode   = '0;
    a_param    = '0;
    a_size     = '0;
    a_source   = '0;
    a_address  = '0;
    a_mask     = '0;
    a_corrupt  = 1'b0;
    d_valid    = 1'b0;
    d_ready    = 1'b0;
    d_opcode   = '0;
    d_param    = '0;
    d_size     = '0;
    d_source   = '0;
    d_denied   = 1'b0;
    d_corrupt  = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    start_test("legal");
    send_a(OP_GET, 3'd0, 2'd2, 2'd0, 32'h100, 4'hF, 1'b0);
    check_val(32'(a_err), 32'd0, "legal Get");
    check_val(32'(pending), 32'h1, "pending after Get");
    send_a(OP_PUT_FULL, 3'd0, 2'd1, 2'd1, 32'h102, 4'b1100, 1'b0);
    check_val(32'(a_err), 32'd0, "legal PutFull");
    check_val(32'(pending), 32'h3, "pending after PutFull");
    send_d(OP_ACCESS_ACK_DATA, 3'd0, 2'd2, 2'd0, 1'b0, 1'b0);
    check_val(32'(d_err), 32'd0, "AccessAckData");
    send_d(OP_ACCESS_ACK, 3'd0, 2'd1, 2'd1, 1'b0, 1'b0);
    check_val(32'(d_err), 32'd0, "AccessAck");
    check_val(32'(pending), 32'h0, "pending after responses");
    end_test();

    start_test("a_faults");
    req_expect(3'd3, 3'd0, 2'd2, 32'h0, 4'hF, 1'b0, AE_OPCODE, "bad opcode");
    req_expect(OP_GET, 3'd1, 2'd2, 32'h0, 4'hF, 1'b0, AE_PARAM, "nonzero param");
    req_expect(OP_GET, 3'd0, 2'd3, 32'h0, 4'hF, 1'b0, AE_SIZE, "size too large");
    req_expect(OP_GET, 3'd0, 2'd2, 32'h102, 4'hF, 1'b0, AE_ALIGN, "misaligned");
    req_expect(OP_GET, 3'd0, 2'd0, 32'h101, 4'b0001, 1'b0, AE_MASK, "lane outside");
    req_expect(OP_GET, 3'd0, 2'd2, 32'h0, 4'b1010, 1'b0, AE_MASK, "sparse Get mask");
    req_expect(OP_PUT_FULL, 3'd0, 2'd1, 32'h0, 4'b0001, 1'b0, AE_FULL_MASK,
               "PutFull mask count");
    req_expect(OP_GET, 3'd0, 2'd2, 32'h0, 4'hF, 1'b1, AE_CORRUPT, "corrupt Get");
    req_expect(OP_PUT_PARTIAL, 3'd0, 2'd2, 32'h0, 4'b1010, 1'b0, -1, "sparse PutPartial");
    end_test();

    start_test("reuse");
    send_a(OP_GET, 3'd0, 2'd2, 2'd1, 32'h40, 4'hF, 1'b0);
    check_val(32'(a_err), 32'd0, "first request");
    send_a(OP_PUT_FULL, 3'd0, 2'd1, 2'd1, 32'h40, 4'b0011, 1'b0);
    check_val(32'(a_err), 32'd1 << AE_REUSE, "reused source");
    check_val(32'(pending), 32'h2, "pending after reuse");
    // The stored Get of size 2 must still match.
    send_d(OP_ACCESS_ACK_DATA, 3'd0, 2'd2, 2'd1, 1'b0, 1'b0);
    check_val(32'(d_err), 32'd0, "response to original request");
    end_test();

    start_test("d_faults");
    send_d(OP_ACCESS_ACK, 3'd0, 2'd0, 2'd0, 1'b0, 1'b0);
    check_val(32'(d_err), 32'd1 << DE_NO_REQ, "response without request");
    resp_expect(1'b1, OP_ACCESS_ACK, 3'd0, 2'd2, 1'b0, 1'b0, DE_MATCH, "Ack to Get");
    resp_expect(1'b0, OP_ACCESS_ACK_DATA, 3'd0, 2'd2, 1'b0, 1'b0, DE_MATCH, "Data to Put");
    resp_expect(1'b0, OP_ACCESS_ACK, 3'd0, 2'd1, 1'b0, 1'b0, DE_SIZE, "wrong size");
    resp_expect(1'b1, OP_ACCESS_ACK_DATA, 3'd2, 2'd2, 1'b0, 1'b0, DE_PARAM, "d param");
    resp_expect(1'b0, OP_ACCESS_ACK, 3'd0, 2'd2, 1'b0, 1'b1, DE_CORRUPT, "corrupt Ack");
    resp_expect(1'b1, OP_ACCESS_ACK_DATA, 3'd0, 2'd2, 1'b1, 1'b0, DE_CORRUPT,
                "denied without corrupt");
    resp_expect(1'b1, 3'd5, 3'd0, 2'd2, 1'b0, 1'b0, DE_OPCODE, "bad D opcode");
    end_test();

    start_test("backpressure");
    send_a(OP_GET, 3'd0, 2'd2, 2'd3, 32'h80, 4'hF, 1'b0);
    // Illegal beats held off by ready must be ignored.
    a_valid   = 1'b1;
    a_ready   = 1'b0;
    a_opcode  = 3'd7;
    a_param   = 3'd5;
    a_source  = 2'd3;
    d_valid   = 1'b1;
    d_ready   = 1'b0;
    d_opcode  = 3'd6;
    d_source  = 2'd3;
    for (int n = 0; n < 4; n++) begin
      @(negedge clk_i);
      check_val(32'(a_err), 32'd0, "a_err under back-pressure");
      check_val(32'(d_err), 32'd0, "d_err under back-pressure");
      check_val(32'(pending), 32'h8, "pending under back-pressure");
    end
    a_valid = 1'b0;
    d_valid = 1'b0;
    send_d(OP_ACCESS_ACK_DATA, 3'd0, 2'd2, 2'd3, 1'b0, 1'b0);
    check_val(32'(d_err), 32'd0, "response after back-pressure");
    end_test();

    start_test("random");
    for (int n = 0; n < RAND_CYCLES; n++) begin
      @(negedge clk_i);
      r  = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      a_valid  = r[0];
      a_ready  = r[1] | r[2];
      a_source = r[4:3];
      a_size   = r[6:5];
      case (r[18:17])
        2'd0:    a_opcode = r[21:19];
        2'd1:    a_opcode = OP_PUT_FULL;
        2'd2:    a_opcode = OP_PUT_PARTIAL;
        default: a_opcode = OP_GET;
      endcase
      a_param   = (r[24:22] == 3'd0) ? r[27:25] : 3'd0;
      a_corrupt = r[28] & r[29] & r[30];
      // Mostly aligned addresses with the natural mask.
      off = int'(r2[2:0]);
      if (r2[3]) begin
        off = off & ~((1 << int'(a_size)) - 1);
      end
      a_address = {r2[31:3], 3'(off)};
      if (r2[4]) begin
        a_mask = r2[8:5];
      end else if (a_size >= 2'd2) begin
        a_mask = 4'hF;
      end else begin
        a_mask = 4'(((1 << (1 << int'(a_size))) - 1) << (off % 4));
      end
      d_valid  = r3[0];
      d_ready  = r3[1] | r3[2];
      d_source = r3[4:3];
      // Three out of four responses match the shadow entry.
      if (r3[6:5] != 2'd0) begin
        d_opcode = sh_get[d_source] ? OP_ACCESS_ACK_DATA : OP_ACCESS_ACK;
        d_size   = sh_size[d_source];
      end else begin
        d_opcode = r3[9:7];
        d_size   = r3[11:10];
      end
      d_param   = (r3[14:12] == 3'd0) ? r3[17:15] : 3'd0;
      d_denied  = r3[18] & r3[19];
      d_corrupt = d_denied ? r3[22] : (r3[23] & r3[24] & r3[25]);
    end
    @(negedge clk_i);
    a_valid   = 1'b0;
    d_valid   = 1'b0;
    d_denied  = 1'b0;
    d_corrupt = 1'b0;
    // Close everything still outstanding.
    for (int s = 0; s < NUM_SRC; s++) begin
      if (sh_valid[s]) begin
        send_d(sh_get[s] ? OP_ACCESS_ACK_DATA : OP_ACCESS_ACK, 3'd0, sh_size[s], 2'(s),
               1'b0, 1'b0);
        check_val(32'(d_err), 32'd0, "drain response");
      end
    end
    check_val(32'(pending), 32'd0, "pending after drain");
    end_test();

    $display("Summary: %0d tests, %0d checks, %0d mismatches", n_tests, n_checks,
             n_errors);
    if (n_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== design/tl_ul_monitor.sv ====
/*
 * Passive TL-UL protocol monitor top level.
 * A checker, pending table and D checker.
 */
`timescale 1ns/1ps

module tl_ul_monitor import tl_mon_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // A channel, observed only.
  input  logic                a_valid,
  input  logic                a_ready,
  input  logic [OPCODE_W-1:0] a_opcode,
  input  logic [PARAM_W-1:0]  a_param,
  input  logic [SIZE_W-1:0]   a_size,
  input  logic [SRC_W-1:0]    a_source,
  input  logic [ADDR_W-1:0]   a_address,
  input  logic [MASK_W-1:0]   a_mask,
  input  logic                a_corrupt,
  // D channel, observed only.
  input  logic                d_valid,
  input  logic                d_ready,
  input  logic [OPCODE_W-1:0] d_opcode,
  input  logic [PARAM_W-1:0]  d_param,
  input  logic [SIZE_W-1:0]   d_size,
  input  logic [SRC_W-1:0]    d_source,
  input  logic                d_denied,
  input  logic                d_corrupt,
  // Error words and outstanding sources.
  output a_err_t              a_err,
  output d_err_t              d_err,
  output logic [NUM_SRC-1:0]  pending
);

  pend_alloc_if  alloc_bus ();
  pend_lookup_if lookup_bus ();

  // Producer side.
  tl_a_checker u_a_checker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .a_valid    (a_valid),
    .a_ready    (a_ready),
    .a_opcode   (a_opcode),
    .a_param    (a_param),
    .a_size     (a_size),
    .a_source   (a_source),
    .a_address  (a_address),
    .a_mask     (a_mask),
    .a_corrupt  (a_corrupt),
    .alloc_port (alloc_bus.producer),
    .a_err      (a_err)
  );

  tl_pend_table u_pend_table (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .alloc_port  (alloc_bus.tbl),
    .lookup_port (lookup_bus.tbl),
    .pending     (pending)
  );

  // Consumer side.
  tl_d_checker u_d_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .d_valid     (d_valid),
    .d_ready     (d_ready),
    .d_opcode    (d_opcode),
    .d_param     (d_param),
    .d_size      (d_size),
    .d_source    (d_source),
    .d_denied    (d_denied),
    .d_corrupt   (d_corrupt),
    .lookup_port (lookup_bus.consumer),
    .d_err       (d_err)
  );

endmodule

// ==== design/tl_d_checker.sv ====
/*
 * D channel rule checks for TL-UL against the pending
 * request of each source, and request release.
 */
`timescale 1ns/1ps

module tl_d_checker import tl_mon_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                d_valid,
  input  logic                d_ready,
  input  logic [OPCODE_W-1:0] d_opcode,
  input  logic [PARAM_W-1:0]  d_param,
  input  logic [SIZE_W-1:0]   d_size,
  input  logic [SRC_W-1:0]    d_source,
  input  logic                d_denied,
  input  logic                d_corrupt,
  pend_lookup_if.consumer     lookup_port,
  output d_err_t              d_err
);

  logic        d_fire;
  logic        is_ack;
  logic        is_ack_data;
  pend_entry_t req;
  d_err_t      d_err_d;

  assign d_fire      = d_valid && d_ready;
  assign is_ack      = (d_opcode == OP_ACCESS_ACK);
  assign is_ack_data = (d_opcode == OP_ACCESS_ACK_DATA);

  ////////////////////
  // Request lookup.
  ////////////////////

  assign lookup_port.lk_src = d_source;
  // Table state from before this edge.
  assign req                = lookup_port.lk_entry;

  // Any accepted response closes its request, legal or not.
  assign lookup_port.dealloc = d_fire && req.valid;

  ////////////////////
  // Rule checks.
  ////////////////////

  always_comb begin
    d_err_d            = '0;
    d_err_d[DE_OPCODE] = !(is_ack || is_ack_data);
    d_err_d[DE_NO_REQ] = !req.valid;
    // Data goes back to Get and a plain ack to Put.
    d_err_d[DE_MATCH]  = req.valid &&
                         ((is_ack_data && !req.is_get) || (is_ack && req.is_get));
    d_err_d[DE_SIZE]   = req.valid && (d_size != req.size);
    d_err_d[DE_PARAM]  = (d_param != '0);
    // Corrupt needs payload.
    // A denied data response must also be marked corrupt.
    d_err_d[DE_CORRUPT] = (is_ack && d_corrupt) ||
                          (is_ack_data && d_denied && !d_corrupt);
  end

  // Registered like the A side, one cycle after the beat.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d_err <= '0;
    end else if (d_fire) begin
      d_err <= d_err_d;
    end else begin
      d_err <= '0;
    end
  end

endmodule

// ==== design/tl_pend_table.sv ====
/*
 * Per-source table of outstanding TL-UL requests.
 */
`timescale 1ns/1ps

module tl_pend_table import tl_mon_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  pend_alloc_if.tbl          alloc_port,
  pend_lookup_if.tbl         lookup_port,
  output logic [NUM_SRC-1:0] pending
);

  // One entry per source ID.
  pend_entry_t [NUM_SRC-1:0] entries_q;
  logic                      same_src_free;

  ////////////////////
  // Update.
  ////////////////////

  // Release is applied first.
  // A same-cycle alloc on that source wins, so the entry stays valid.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      entries_q <= '0;
    end else begin
      if (lookup_port.dealloc) begin
        entries_q[lookup_port.lk_src].valid <= 1'b0;
      end
      if (alloc_port.alloc) begin
        entries_q[alloc_port.alloc_src] <= '{
          valid:  1'b1,
          is_get: alloc_port.alloc_is_get,
          size:   alloc_port.alloc_size
        };
      end
    end
  end

  ////////////////////
  // Read ports.
  ////////////////////

  // The response in this cycle frees the source that A wants.
  assign same_src_free = lookup_port.dealloc &&
                         (lookup_port.lk_src == alloc_port.alloc_src);

  assign alloc_port.busy      = entries_q[alloc_port.alloc_src].valid && !same_src_free;
  // D side sees the state from before the edge.
  assign lookup_port.lk_entry = entries_q[lookup_port.lk_src];

  // Outstanding requests, visible one cycle after the beat.
  always_comb begin
    for (int i = 0; i < NUM_SRC; i++) begin
      pending[i] = entries_q[i].valid;
    end
  end

  // The D checker may only free what the A checker allocated.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lookup_port.dealloc |-> entries_q[lookup_port.lk_src].valid)
    else $error("release of an empty table entry");

  // Table entries must never be overwritten by a new request.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    alloc_port.alloc |-> (!entries_q[alloc_port.alloc_src].valid || same_src_free))
    else $error("alloc issued on a busy source");

endmodule

// ==== design/tl_a_checker.sv ====
/*
 * A channel rule checks for TL-UL and request allocation
 * into the pending table.
 */
`timescale 1ns/1ps

module tl_a_checker import tl_mon_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                a_valid,
  input  logic                a_ready,
  input  logic [OPCODE_W-1:0] a_opcode,
  input  logic [PARAM_W-1:0]  a_param,
  input  logic [SIZE_W-1:0]   a_size,
  input  logic [SRC_W-1:0]    a_source,
  input  logic [ADDR_W-1:0]   a_address,
  input  logic [MASK_W-1:0]   a_mask,
  input  logic                a_corrupt,
  pend_alloc_if.producer      alloc_port,
  output a_err_t              a_err
);

  // Beat is sampled only on the handshake.
  logic                     a_fire;
  logic                     op_legal;
  logic                     contig_req;
  logic [BYTE_CNT_W-1:0]    byte_cnt;
  logic [BYTE_CNT_W-1:0]    align_mask;
  logic [BUS_BYTES_LOG-1:0] lane_off;
  logic [MASK_W-1:0]        max_mask;
  logic [MASK_W-1:0]        mask_edges;
  a_err_t                   a_err_d;

  assign a_fire   = a_valid && a_ready;
  assign op_legal = (a_opcode == OP_PUT_FULL) || (a_opcode == OP_PUT_PARTIAL) ||
                    (a_opcode == OP_GET);
  // PutPartialData may carry a sparse mask.
  assign contig_req = (a_opcode == OP_GET) || (a_opcode == OP_PUT_FULL);

  ////////////////////
  // Mask geometry.
  ////////////////////

  // Transfer length in bytes and the address bits it must clear.
  assign byte_cnt   = BYTE_CNT_W'(1) << a_size;
  assign align_mask = byte_cnt - BYTE_CNT_W'(1);
  // Byte lane of the first addressed byte.
  assign lane_off   = a_address[BUS_BYTES_LOG-1:0];

  // Largest mask the size and address allow.
  always_comb begin
    if (a_size >= SIZE_W'(BUS_BYTES_LOG)) begin
      max_mask = '1;
    end else begin
      max_mask = MASK_W'((32'd1 << byte_cnt) - 32'd1) << lane_off;
    end
  end

  // A contiguous run of ones has at most two edges.
  assign mask_edges = a_mask ^ {a_mask[MASK_W-2:0], 1'b0};

  ////////////////////
  // Rule checks.
  ////////////////////

  always_comb begin
    a_err_d               = '0;
    a_err_d[AE_OPCODE]    = !op_legal;
    a_err_d[AE_PARAM]     = (a_param != '0);
    a_err_d[AE_SIZE]      = (a_size > SIZE_W'(BUS_BYTES_LOG));
    a_err_d[AE_ALIGN]     = |(a_address[BYTE_CNT_W-1:0] & align_mask);
    a_err_d[AE_MASK]      = ((a_mask & ~max_mask) != '0) ||
                            (contig_req && ($countones(mask_edges) > 2));
    a_err_d[AE_FULL_MASK] = (a_opcode == OP_PUT_FULL) &&
                            ($countones(a_mask) != int'(byte_cnt));
    // Get is the only request without payload.
    a_err_d[AE_CORRUPT]   = a_corrupt && (a_opcode == OP_GET);
    // Illegal opcodes are not tracked as requests.
    a_err_d[AE_REUSE]     = op_legal && alloc_port.busy;
  end

  // Error word lives for exactly one cycle after the beat.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_err <= '0;
    end else if (a_fire) begin
      a_err <= a_err_d;
    end else begin
      a_err <= '0;
    end
  end

  ////////////////////
  // Allocation.
  ////////////////////

  // A busy source keeps its old entry.
  assign alloc_port.alloc        = a_fire && op_legal && !alloc_port.busy;
  assign alloc_port.alloc_src    = a_source;
  assign alloc_port.alloc_is_get = (a_opcode == OP_GET);
  assign alloc_port.alloc_size   = a_size;

endmodule

// ==== design/tl_mon_if.sv ====
/*
 * Allocation and lookup interfaces between the channel
 * checkers and the pending-request table.
 */
`timescale 1ns/1ps

// A checker to table.
// New requests are written here.
interface pend_alloc_if import tl_mon_pkg::*; ();

  // One-cycle strobe per accepted legal request.
  logic              alloc;
  logic [SRC_W-1:0]  alloc_src;
  logic              alloc_is_get;
  logic [SIZE_W-1:0] alloc_size;
  // Entry of alloc_src still in use after this cycle's release.
  logic              busy;

  modport producer (
    output alloc,
    output alloc_src,
    output alloc_is_get,
    output alloc_size,
    input  busy
  );

  modport tbl (
    input  alloc,
    input  alloc_src,
    input  alloc_is_get,
    input  alloc_size,
    output busy
  );

endinterface

// D checker to table.
// Responses read their request here and free it.
interface pend_lookup_if import tl_mon_pkg::*; ();

  logic [SRC_W-1:0] lk_src;
  pend_entry_t      lk_entry;
  // One-cycle strobe that frees the entry of lk_src.
  logic             dealloc;

  modport consumer (
    output lk_src,
    output dealloc,
    input  lk_entry
  );

  modport tbl (
    input  lk_src,
    input  dealloc,
    output lk_entry
  );

endinterface

// ==== design/tl_mon_pkg.sv ====
/*
 * Shared widths, TL-UL opcodes, error bit positions and
 * the pending-table entry type for the TL-UL monitor.
 */
package tl_mon_pkg;

  //////////////////////
  // Bus widths.
  //////////////////////

  localparam int unsigned ADDR_W        = 32;
  localparam int unsigned DATA_W        = 32;
  // One mask bit per byte lane.
  localparam int unsigned MASK_W        = DATA_W / 8;
  localparam int unsigned SIZE_W        = 2;
  localparam int unsigned SRC_W         = 2;
  localparam int unsigned OPCODE_W      = 3;
  localparam int unsigned PARAM_W       = 3;
  // One table entry per source ID.
  localparam int unsigned NUM_SRC       = 2 ** SRC_W;
  localparam int unsigned BUS_BYTES_LOG = $clog2(MASK_W);
  // Wide enough to hold 2**size for the largest size code.
  localparam int unsigned BYTE_CNT_W    = 2 ** SIZE_W;

  //////////////////////
  // Opcodes.
  //////////////////////

  // A channel requests.
  localparam logic [OPCODE_W-1:0] OP_PUT_FULL        = 3'd0;
  localparam logic [OPCODE_W-1:0] OP_PUT_PARTIAL     = 3'd1;
  localparam logic [OPCODE_W-1:0] OP_GET             = 3'd4;
  // D channel responses.
  localparam logic [OPCODE_W-1:0] OP_ACCESS_ACK      = 3'd0;
  localparam logic [OPCODE_W-1:0] OP_ACCESS_ACK_DATA = 3'd1;

  //////////////////////
  // Error words.
  //////////////////////

  // A channel error bit positions.
  localparam int unsigned A_ERR_W      = 8;
  localparam int unsigned AE_OPCODE    = 0;
  localparam int unsigned AE_PARAM     = 1;
  localparam int unsigned AE_SIZE      = 2;
  localparam int unsigned AE_ALIGN     = 3;
  localparam int unsigned AE_MASK      = 4;
  localparam int unsigned AE_FULL_MASK = 5;
  localparam int unsigned AE_CORRUPT   = 6;
  localparam int unsigned AE_REUSE     = 7;

  // D channel error bit positions.
  localparam int unsigned D_ERR_W    = 6;
  localparam int unsigned DE_OPCODE  = 0;
  localparam int unsigned DE_NO_REQ  = 1;
  localparam int unsigned DE_MATCH   = 2;
  localparam int unsigned DE_SIZE    = 3;
  localparam int unsigned DE_PARAM   = 4;
  localparam int unsigned DE_CORRUPT = 5;

  typedef logic [A_ERR_W-1:0] a_err_t;
  typedef logic [D_ERR_W-1:0] d_err_t;

  // One outstanding request as seen by the D side.
  typedef struct packed {
    logic              valid;
    logic              is_get;
    logic [SIZE_W-1:0] size;
  } pend_entry_t;

endpackage
